// File: Makefile
SRCS := $(shell cat src.f)

.PHONY: run clean

run: obj_dir/Vtb_hazard
	@out="$$(./obj_dir/Vtb_hazard)"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

obj_dir/Vtb_hazard: src.f $(SRCS)
	verilator --binary --assert --top-module tb_hazard -f src.f -o Vtb_hazard

clean:
	rm -rf obj_dir

// File: forward_unit.sv
`timescale 1ns/10ps

module forward_unit import hazard_pkg::*; (
  stage_if.consumer e_stage,
  stage_if.consumer m_stage,
  stage_if.consumer w_stage,
  output fwd_sel_e  fwd_a,
  output fwd_sel_e  fwd_b
);

  // source choice for one E operand, M has priority over W
  function automatic fwd_sel_e pick_src(
    input logic [reg_addr_w-1:0] rs,
    input logic [reg_addr_w-1:0] m_rd,
    input logic                  m_write,
    input result_src_e           m_src,
    input logic [reg_addr_w-1:0] w_rd,
    input logic                  w_write
  );
    logic     m_hit;
    logic     w_hit;
    fwd_sel_e sel;
    m_hit = (rs != reg_zero) && m_write && (rs == m_rd);
    w_hit = (rs != reg_zero) && w_write && (rs == w_rd);
    if (m_hit && (m_src == res_alu)) begin
      sel = fwd_m_alu;
    end else if (m_hit && (m_src == res_imm_plus)) begin
      sel = fwd_m_imm_plus;
    end else if (w_hit) begin
      // also reached when M matches but its value is not ready yet
      sel = fwd_w_result;
    end else begin
      sel = fwd_reg;
    end
    return sel;
  endfunction

  assign fwd_a = pick_src(e_stage.rs1,
                          m_stage.rd, m_stage.reg_write, m_stage.result_src,
                          w_stage.rd, w_stage.reg_write);

  assign fwd_b = pick_src(e_stage.rs2,
                          m_stage.rd, m_stage.reg_write, m_stage.result_src,
                          w_stage.rd, w_stage.reg_write);

  // x0 operands always come from the register file
  assert property (@(posedge e_stage.clk)
    ((e_stage.rs1 == reg_zero) |-> (fwd_a == fwd_reg)) and
    ((e_stage.rs2 == reg_zero) |-> (fwd_b == fwd_reg)))
    else $error("forward_unit: x0 operand forwarded at %0t", $time);

endmodule

// File: hazard_pkg.sv
package hazard_pkg;

  localparam int xlen       = 32;  // operand width
  localparam int reg_addr_w = 5;   // x0..x31

  // x0 reads as zero, so it is never a real dependency
  localparam logic [reg_addr_w-1:0] reg_zero = '0;

  // where an instruction's result comes from
  typedef enum logic [1:0] {
    res_alu      = 2'b00,
    res_load     = 2'b01,  // only ready in W
    res_imm_plus = 2'b10,  // lui / auipc sum, ready in M
    res_pc_plus4 = 2'b11   // link value of jal / jalr
  } result_src_e;

  // next-PC choice, resolved in E
  typedef enum logic [1:0] {
    pc_plus4  = 2'b00,  // sequential, the only non-redirect
    pc_branch = 2'b01,
    pc_jal    = 2'b10,
    pc_jalr   = 2'b11
  } pc_src_e;

  // operand source, ordered as the mux inputs
  typedef enum logic [1:0] {
    fwd_reg        = 2'b00,  // value read from the register file
    fwd_w_result   = 2'b01,
    fwd_m_imm_plus = 2'b10,
    fwd_m_alu      = 2'b11
  } fwd_sel_e;

endpackage

// File: hazard_resolve.sv
`timescale 1ns/10ps

module hazard_resolve import hazard_pkg::*; (
  input  fwd_sel_e        fwd_a,
  input  fwd_sel_e        fwd_b,
  input  logic            load_use,
  input  logic            redirect,
  input  logic [xlen-1:0] e_rd1,
  input  logic [xlen-1:0] e_rd2,
  input  logic [xlen-1:0] m_alu_out,
  input  logic [xlen-1:0] m_imm_plus,
  input  logic [xlen-1:0] w_result,
  output logic [xlen-1:0] src_a,
  output logic [xlen-1:0] src_b,
  output logic            f_stall,
  output logic            d_stall,
  output logic            d_flush,
  output logic            e_flush
);

  // one operand mux, four sources
  function automatic logic [xlen-1:0] operand_mux(
    input fwd_sel_e        sel,
    input logic [xlen-1:0] reg_val,
    input logic [xlen-1:0] m_alu,
    input logic [xlen-1:0] m_imm,
    input logic [xlen-1:0] w_val
  );
    logic [xlen-1:0] val;
    case (sel)
      fwd_w_result:   val = w_val;
      fwd_m_imm_plus: val = m_imm;
      fwd_m_alu:      val = m_alu;
      default:        val = reg_val;
    endcase
    return val;
  endfunction

  assign src_a = operand_mux(fwd_a, e_rd1, m_alu_out, m_imm_plus, w_result);
  assign src_b = operand_mux(fwd_b, e_rd2, m_alu_out, m_imm_plus, w_result);

  always_comb begin
    f_stall = load_use;              // hold PC
    d_stall = load_use;              // hold the consumer in D
    d_flush = redirect;              // wrong-path instruction in D
    e_flush = redirect || load_use;  // bubble into E for either case

    // a held D without a bubble behind it would issue the consumer twice
    if (f_stall || d_stall) begin
      assert (e_flush && (f_stall == d_stall))
        else $error("hazard_resolve: stall without E flush at %0t", $time);
    end
  end

endmodule

// File: hazard_top.sv
`timescale 1ns/10ps

module hazard_top import hazard_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_x,
  // decoded D fields
  input  logic [reg_addr_w-1:0] d_rs1,
  input  logic [reg_addr_w-1:0] d_rs2,
  input  logic [reg_addr_w-1:0] d_rd,
  input  logic                  d_reg_write,
  input  result_src_e           d_result_src,
  // resolved in E
  input  pc_src_e               e_pc_src,
  // datapath values
  input  logic [xlen-1:0]       e_rd1,
  input  logic [xlen-1:0]       e_rd2,
  input  logic [xlen-1:0]       m_alu_out,
  input  logic [xlen-1:0]       m_imm_plus,
  input  logic [xlen-1:0]       w_result,
  // to the E operand inputs
  output logic [xlen-1:0]       src_a,
  output logic [xlen-1:0]       src_b,
  // pipeline controls
  output logic                  f_stall,
  output logic                  d_stall,
  output logic                  d_flush,
  output logic                  e_flush
);

  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  logic     load_use;
  logic     redirect;

  stage_if e_stage (.clk(clk));
  stage_if m_stage (.clk(clk));
  stage_if w_stage (.clk(clk));

  pipe_regs u_pipe_regs (
    .clk          (clk),
    .reset_x      (reset_x),
    .d_rs1        (d_rs1),
    .d_rs2        (d_rs2),
    .d_rd         (d_rd),
    .d_reg_write  (d_reg_write),
    .d_result_src (d_result_src),
    .e_pc_src     (e_pc_src),
    .e_flush      (e_flush),   // fed back from hazard_resolve
    .e_stage      (e_stage.producer),
    .m_stage      (m_stage.producer),
    .w_stage      (w_stage.producer)
  );

  forward_unit u_forward_unit (
    .e_stage (e_stage.consumer),
    .m_stage (m_stage.consumer),
    .w_stage (w_stage.consumer),
    .fwd_a   (fwd_a),
    .fwd_b   (fwd_b)
  );

  stall_detect u_stall_detect (
    .d_rs1    (d_rs1),
    .d_rs2    (d_rs2),
    .e_stage  (e_stage.consumer),
    .load_use (load_use),
    .redirect (redirect)
  );

  hazard_resolve u_hazard_resolve (
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .load_use   (load_use),
    .redirect   (redirect),
    .e_rd1      (e_rd1),
    .e_rd2      (e_rd2),
    .m_alu_out  (m_alu_out),
    .m_imm_plus (m_imm_plus),
    .w_result   (w_result),
    .src_a      (src_a),
    .src_b      (src_b),
    .f_stall    (f_stall),
    .d_stall    (d_stall),
    .d_flush    (d_flush),
    .e_flush    (e_flush)
  );

endmodule

// File: pipe_regs.sv
`timescale 1ns/10ps

module pipe_regs import hazard_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_x,
  input  logic [reg_addr_w-1:0] d_rs1,
  input  logic [reg_addr_w-1:0] d_rs2,
  input  logic [reg_addr_w-1:0] d_rd,
  input  logic                  d_reg_write,
  input  result_src_e           d_result_src,
  input  pc_src_e               e_pc_src,
  input  logic                  e_flush,
  stage_if.producer             e_stage,
  stage_if.producer             m_stage,
  stage_if.producer             w_stage
);

  logic d_writes;

  // a write to x0 is dropped on entry, later stages never see it as a producer
  assign d_writes = d_reg_write && (d_rd != reg_zero);

  // branch outcome only exists in E, so it is not registered here
  assign e_stage.pc_src = e_pc_src;

  // D -> E, reset and flush both leave a bubble
  always_ff @(posedge clk) begin
    if (reset_x || e_flush) begin
      e_stage.rs1        <= reg_zero;
      e_stage.rs2        <= reg_zero;
      e_stage.rd         <= reg_zero;
      e_stage.reg_write  <= 1'b0;
      e_stage.result_src <= res_alu;
    end else begin
      e_stage.rs1        <= d_rs1;
      e_stage.rs2        <= d_rs2;
      e_stage.rd         <= d_rd;
      e_stage.reg_write  <= d_writes;
      e_stage.result_src <= d_result_src;
    end
  end

  // E -> M every cycle
  always_ff @(posedge clk) begin
    if (reset_x) begin
      m_stage.rs1        <= reg_zero;
      m_stage.rs2        <= reg_zero;
      m_stage.rd         <= reg_zero;
      m_stage.reg_write  <= 1'b0;
      m_stage.result_src <= res_alu;
      m_stage.pc_src     <= pc_plus4;
    end else begin
      m_stage.rs1        <= e_stage.rs1;
      m_stage.rs2        <= e_stage.rs2;
      m_stage.rd         <= e_stage.rd;
      m_stage.reg_write  <= e_stage.reg_write;
      m_stage.result_src <= e_stage.result_src;
      m_stage.pc_src     <= e_stage.pc_src;   // branch that redirected, kept for trace
    end
  end

  // M -> W every cycle
  always_ff @(posedge clk) begin
    if (reset_x) begin
      w_stage.rs1        <= reg_zero;
      w_stage.rs2        <= reg_zero;
      w_stage.rd         <= reg_zero;
      w_stage.reg_write  <= 1'b0;
      w_stage.result_src <= res_alu;
      w_stage.pc_src     <= pc_plus4;
    end else begin
      w_stage.rs1        <= m_stage.rs1;
      w_stage.rs2        <= m_stage.rs2;
      w_stage.rd         <= m_stage.rd;
      w_stage.reg_write  <= m_stage.reg_write;
      w_stage.result_src <= m_stage.result_src;
      w_stage.pc_src     <= m_stage.pc_src;
    end
  end

  // an x0 destination presented in D never arrives in W as a write
  assert property (@(posedge clk) disable iff (reset_x)
    (d_reg_write && (d_rd == reg_zero)) |-> ##3 !w_stage.reg_write)
    else $error("pipe_regs: x0 write reached W at %0t", $time);

endmodule

// File: src.f
hazard_pkg.sv
stage_if.sv
pipe_regs.sv
forward_unit.sv
stall_detect.sv
hazard_resolve.sv
hazard_top.sv
tb_hazard.sv

// File: stage_if.sv
`timescale 1ns/10ps

// control fields of one pipeline stage
interface stage_if import hazard_pkg::*; (
  input logic clk
);

  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic                  reg_write;
  result_src_e           result_src;
  pc_src_e               pc_src;

  // stage register side
  modport producer (
    input  clk,
    output rs1, rs2, rd, reg_write, result_src, pc_src
  );

  // hazard logic side, read only
  modport consumer (
    input clk,
    input rs1, rs2, rd, reg_write, result_src, pc_src
  );

endinterface

// File: stall_detect.sv
`timescale 1ns/10ps

module stall_detect import hazard_pkg::*; (
  input  logic [reg_addr_w-1:0] d_rs1,
  input  logic [reg_addr_w-1:0] d_rs2,
  stage_if.consumer             e_stage,
  output logic                  load_use,
  output logic                  redirect
);

  logic e_is_load;  // E will write a loaded value
  logic d_needs_e;  // D reads what E writes

  assign e_is_load = (e_stage.result_src == res_load) && (e_stage.rd != reg_zero);
  assign d_needs_e = (d_rs1 == e_stage.rd) || (d_rs2 == e_stage.rd);

  // load value reaches W two cycles later, one too late for M forwarding
  assign load_use = e_is_load && d_needs_e;

  // anything but the sequential PC throws away D and E
  assign redirect = (e_stage.pc_src != pc_plus4);

  // the stalled consumer must be preceded by a bubble in E
  assert property (@(posedge e_stage.clk)
    load_use |=> (!e_stage.reg_write && (e_stage.rd == reg_zero)))
    else $error("stall_detect: no bubble after load-use at %0t", $time);

  // a redirecting instruction is never followed by a live one in E
  assert property (@(posedge e_stage.clk)
    redirect |=> !e_stage.reg_write)
    else $error("stall_detect: E not flushed after redirect at %0t", $time);

endmodule

// File: tb_hazard.sv
`timescale 1ns/10ps

module tb_hazard import hazard_pkg::*; ();

  localparam int cycle_limit = 6 * 200 + 40;  // six tests of up to 200 cycles, plus reset

  // control fields of one modelled stage
  typedef struct packed {
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic                  wr;
    result_src_e           src;
  } stage_t;

  localparam stage_t bubble = '{rs1: '0, rs2: '0, rd: '0, wr: 1'b0, src: res_alu};

  logic                  clk;
  logic                  reset_x;
  logic [reg_addr_w-1:0] d_rs1;
  logic [reg_addr_w-1:0] d_rs2;
  logic [reg_addr_w-1:0] d_rd;
  logic                  d_reg_write;
  result_src_e           d_result_src;
  pc_src_e               e_pc_src;
  logic [xlen-1:0]       e_rd1;
  logic [xlen-1:0]       e_rd2;
  logic [xlen-1:0]       m_alu_out;
  logic [xlen-1:0]       m_imm_plus;
  logic [xlen-1:0]       w_result;
  logic [xlen-1:0]       src_a;
  logic [xlen-1:0]       src_b;
  logic                  f_stall;
  logic                  d_stall;
  logic                  d_flush;
  logic                  e_flush;

  stage_t          ref_e;  // reference pipeline
  stage_t          ref_m;
  stage_t          ref_w;
  logic [xlen-1:0] exp_src_a;
  logic [xlen-1:0] exp_src_b;
  logic            exp_load_use;
  logic            exp_redirect;
  logic            exp_e_flush;

  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  logic [31:0] lcg_state = 32'hb6b76eb1;

  hazard_top dut (
    .clk          (clk),
    .reset_x      (reset_x),
    .d_rs1        (d_rs1),
    .d_rs2        (d_rs2),
    .d_rd         (d_rd),
    .d_reg_write  (d_reg_write),
    .d_result_src (d_result_src),
    .e_pc_src     (e_pc_src),
    .e_rd1        (e_rd1),
    .e_rd2        (e_rd2),
    .m_alu_out    (m_alu_out),
    .m_imm_plus   (m_imm_plus),
    .w_result     (w_result),
    .src_a        (src_a),
    .src_b        (src_b),
    .f_stall      (f_stall),
    .d_stall      (d_stall),
    .d_flush      (d_flush),
    .e_flush      (e_flush)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // operand value expected for one E source
  function automatic logic [xlen-1:0] fwd_value(
    input logic [reg_addr_w-1:0] rs,
    input logic [xlen-1:0]       reg_val,
    input stage_t                m,
    input stage_t                w,
    input logic [xlen-1:0]       m_alu,
    input logic [xlen-1:0]       m_imm,
    input logic [xlen-1:0]       w_val
  );
    logic            m_hit;
    logic            w_hit;
    logic [xlen-1:0] val;
    m_hit = (rs != '0) && m.wr && (m.rd == rs);
    w_hit = (rs != '0) && w.wr && (w.rd == rs);
    val = reg_val;
    if (w_hit)
      val = w_val;
    // M overrides W, but a load in M has no value yet
    if (m_hit && (m.src == res_alu))
      val = m_alu;
    else if (m_hit && (m.src == res_imm_plus))
      val = m_imm;
    return val;
  endfunction

  always_comb begin
    exp_load_use = (ref_e.src == res_load) && (ref_e.rd != '0) &&
                   ((d_rs1 == ref_e.rd) || (d_rs2 == ref_e.rd));
    exp_redirect = (e_pc_src != pc_plus4);
    exp_e_flush  = exp_load_use || exp_redirect;
    exp_src_a = fwd_value(ref_e.rs1, e_rd1, ref_m, ref_w, m_alu_out, m_imm_plus, w_result);
    exp_src_b = fwd_value(ref_e.rs2, e_rd2, ref_m, ref_w, m_alu_out, m_imm_plus, w_result);
  end

  always @(posedge clk) begin
    if (reset_x) begin
      ref_e <= bubble;
      ref_m <= bubble;
      ref_w <= bubble;
    end else begin
      if (exp_e_flush)
        ref_e <= bubble;
      else
        ref_e <= '{rs1: d_rs1, rs2: d_rs2, rd: d_rd, wr: d_reg_write, src: d_result_src};
      ref_m <= ref_e;
      ref_w <= ref_m;
    end
  end

  task automatic report_mismatch(input string name, input logic [xlen-1:0] got,
                                 input logic [xlen-1:0] want);
    errors++;
    $display("error at %0t: %s = %h, expected %h", $time, name, got, want);
  endtask

  assert property (@(posedge clk) disable iff (reset_x) src_a == exp_src_a)
    else report_mismatch("src_a", $sampled(src_a), $sampled(exp_src_a));
  assert property (@(posedge clk) disable iff (reset_x) src_b == exp_src_b)
    else report_mismatch("src_b", $sampled(src_b), $sampled(exp_src_b));
  assert property (@(posedge clk) disable iff (reset_x) f_stall == exp_load_use)
    else report_mismatch("f_stall", 32'($sampled(f_stall)), 32'($sampled(exp_load_use)));
  assert property (@(posedge clk) disable iff (reset_x) d_stall == exp_load_use)
    else report_mismatch("d_stall", 32'($sampled(d_stall)), 32'($sampled(exp_load_use)));
  assert property (@(posedge clk) disable iff (reset_x) d_flush == exp_redirect)
    else report_mismatch("d_flush", 32'($sampled(d_flush)), 32'($sampled(exp_redirect)));
  assert property (@(posedge clk) disable iff (reset_x) e_flush == exp_e_flush)
    else report_mismatch("e_flush", 32'($sampled(e_flush)), 32'($sampled(exp_e_flush)));

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic new_data();
    e_rd1      = rand32();
    e_rd2      = rand32();
    m_alu_out  = rand32();
    m_imm_plus = rand32();
    w_result   = rand32();
  endtask

  // present one instruction in D, pc belongs to whatever sits in E now
  task automatic issue(
    input logic [reg_addr_w-1:0] rs1,
    input logic [reg_addr_w-1:0] rs2,
    input logic [reg_addr_w-1:0] rd,
    input logic                  wr,
    input result_src_e           src,
    input pc_src_e               pc
  );
    @(negedge clk);
    d_rs1        = rs1;
    d_rs2        = rs2;
    d_rd         = rd;
    d_reg_write  = wr;
    d_result_src = src;
    e_pc_src     = pc;
    new_data();
    #1;
    while (exp_load_use) begin  // held in D behind the bubble
      @(negedge clk);
      e_pc_src = pc_plus4;
      new_data();
      #1;
    end
  endtask

  task automatic drain(input int count);
    repeat (count) issue('0, '0, '0, 1'b0, res_alu, pc_plus4);
  endtask

  // indices from x0..x3 so that hazards are frequent
  task automatic random_burst(input int count);
    logic [31:0] r;
    pc_src_e     pc;
    for (int i = 0; i < count; i++) begin
      r  = rand32();
      pc = (r[15:13] == 3'd0) ? pc_src_e'(r[17:16] | 2'b01) : pc_plus4;
      issue({3'b0, r[31:30]}, {3'b0, r[29:28]}, {3'b0, r[27:26]}, r[25],
            result_src_e'(r[24:23]), pc);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset_x     = 1'b1;
    d_reg_write = 1'b0;
    e_pc_src    = pc_plus4;
    repeat (2) @(negedge clk);
    reset_x = 1'b0;
  endtask

  task automatic finish_test(input string name, input int err_mark);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, errors - err_mark);
    end
  endtask

  initial begin
    int err_mark;
    reset_x      = 1'b1;
    d_rs1        = '0;
    d_rs2        = '0;
    d_rd         = '0;
    d_reg_write  = 1'b0;
    d_result_src = res_alu;
    e_pc_src     = pc_plus4;
    e_rd1        = '0;
    e_rd2        = '0;
    m_alu_out    = '0;
    m_imm_plus   = '0;
    w_result     = '0;
    repeat (2) @(negedge clk);
    reset_x = 1'b0;

    err_mark = errors;
    issue(5'd0, 5'd0, 5'd1, 1'b1, res_alu, pc_plus4);
    issue(5'd1, 5'd2, 5'd3, 1'b1, res_alu, pc_plus4);       // x1 from M alu
    issue(5'd0, 5'd0, 5'd4, 1'b1, res_imm_plus, pc_plus4);
    issue(5'd4, 5'd4, 5'd5, 1'b1, res_alu, pc_plus4);       // both from M imm sum
    drain(3);
    finish_test("m forwarding", err_mark);

    err_mark = errors;
    issue(5'd0, 5'd0, 5'd6, 1'b1, res_alu, pc_plus4);
    issue(5'd0, 5'd0, 5'd7, 1'b1, res_alu, pc_plus4);
    issue(5'd6, 5'd0, 5'd8, 1'b1, res_alu, pc_plus4);       // x6 two ahead, from W
    issue(5'd0, 5'd0, 5'd9, 1'b1, res_alu, pc_plus4);
    issue(5'd0, 5'd0, 5'd9, 1'b1, res_imm_plus, pc_plus4);
    issue(5'd9, 5'd9, 5'd10, 1'b1, res_alu, pc_plus4);      // M and W both x9
    random_burst(60);
    drain(3);
    finish_test("w forwarding and priority", err_mark);

    err_mark = errors;
    issue(5'd0, 5'd0, 5'd0, 1'b1, res_alu, pc_plus4);       // writes x0
    issue(5'd0, 5'd0, 5'd0, 1'b1, res_imm_plus, pc_plus4);
    issue(5'd0, 5'd0, 5'd1, 1'b1, res_alu, pc_plus4);
    drain(3);
    finish_test("x0 sources", err_mark);

    err_mark = errors;
    issue(5'd0, 5'd0, 5'd11, 1'b1, res_load, pc_plus4);
    issue(5'd11, 5'd0, 5'd12, 1'b1, res_alu, pc_plus4);     // one stall, then W
    issue(5'd12, 5'd11, 5'd0, 1'b0, res_alu, pc_plus4);
    issue(5'd0, 5'd0, 5'd7, 1'b1, res_load, pc_plus4);
    issue(5'd3, 5'd7, 5'd8, 1'b1, res_alu, pc_plus4);       // rs2 side
    issue(5'd0, 5'd0, 5'd9, 1'b1, res_load, pc_plus4);
    issue(5'd0, 5'd0, 5'd0, 1'b0, res_alu, pc_plus4);
    issue(5'd9, 5'd0, 5'd2, 1'b1, res_alu, pc_plus4);       // no stall, load in W
    issue(5'd0, 5'd0, 5'd0, 1'b1, res_load, pc_plus4);
    issue(5'd0, 5'd0, 5'd1, 1'b1, res_alu, pc_plus4);       // load to x0 never stalls
    drain(3);
    finish_test("load use stall", err_mark);

    err_mark = errors;
    issue(5'd0, 5'd0, 5'd13, 1'b1, res_alu, pc_plus4);
    issue(5'd13, 5'd0, 5'd14, 1'b1, res_pc_plus4, pc_plus4); // jal linking x14
    issue(5'd14, 5'd0, 5'd15, 1'b1, res_alu, pc_jal);       // squashed
    issue(5'd14, 5'd15, 5'd16, 1'b1, res_alu, pc_plus4);    // E bubble here
    issue(5'd14, 5'd15, 5'd17, 1'b1, res_alu, pc_plus4);
    issue(5'd0, 5'd0, 5'd0, 1'b0, res_alu, pc_plus4);       // branch
    issue(5'd1, 5'd1, 5'd2, 1'b1, res_alu, pc_branch);      // squashed
    issue(5'd2, 5'd0, 5'd3, 1'b1, res_alu, pc_plus4);
    issue(5'd0, 5'd0, 5'd0, 1'b0, res_alu, pc_plus4);       // jalr
    issue(5'd3, 5'd3, 5'd4, 1'b1, res_alu, pc_jalr);
    drain(3);
    finish_test("redirect flush", err_mark);

    err_mark = errors;
    issue(5'd0, 5'd0, 5'd1, 1'b1, res_alu, pc_plus4);       // producers cut off by reset
    issue(5'd0, 5'd0, 5'd2, 1'b1, res_alu, pc_plus4);
    apply_reset();
    issue(5'd1, 5'd2, 5'd3, 1'b1, res_alu, pc_plus4);
    issue(5'd1, 5'd2, 5'd0, 1'b0, res_alu, pc_plus4);
    issue(5'd3, 5'd3, 5'd0, 1'b0, res_alu, pc_plus4);       // first real forward
    drain(3);
    finish_test("after reset", err_mark);

    @(negedge clk);
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if ((errors == 0) && (tests_failed == 0)) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
